// File: src/pmp_stream_pkg.sv
/*
 * Widths of the register write stream and of the modulation values
 */
`default_nettype none

package pmp_stream_pkg;

    // Write stream
    localparam int data_width = 32;
    localparam int addr_width = 32;

    // Period, duty, deadtime and phase shift values
    localparam int value_width = 16;

    // Active phase count, stored as count minus one
    localparam int count_width = 4;

endpackage

`default_nettype wire

// File: src/pmp_regmap_pkg.sv
/*
 * PWM generator register map: per-channel register offsets, channel stride
 * and the control words written to the control register
 */
`default_nettype none

package pmp_regmap_pkg;

    // Byte offsets of the registers inside one phase channel
    localparam logic [31:0] reg_period   = 32'h0000_0000;
    localparam logic [31:0] reg_duty     = 32'h0000_0004;
    localparam logic [31:0] reg_shift    = 32'h0000_0008;
    localparam logic [31:0] reg_deadtime = 32'h0000_000C;
    localparam logic [31:0] reg_control  = 32'h0000_0010;

    // Each phase channel occupies its own block of registers
    localparam logic [31:0] channel_stride = 32'h0000_0040;

    // Control register words
    localparam logic [31:0] ctrl_enable = 32'h0000_0001;
    localparam logic [31:0] ctrl_start  = 32'h0000_0003;
    localparam logic [31:0] ctrl_stop   = 32'h0000_0002;

endpackage

`default_nettype wire

// File: src/reg_write_if.sv
/*
 * Register write stream with valid/ready handshake and last framing
 */
`timescale 1ns/1ps
`default_nettype none

interface reg_write_if;

    logic [pmp_stream_pkg::data_width-1:0] data;
    logic [pmp_stream_pkg::addr_width-1:0] addr;
    logic last;
    logic valid;
    logic ready;

    modport source (output data, addr, last, valid, input ready);

    modport sink (input data, addr, last, valid, output ready);

endinterface

`default_nettype wire

// File: src/phase_shift_calc.sv
/*
 * Per-phase shift calculator built around one restoring divider
 */
`timescale 1ns/1ps
`default_nettype none

module phase_shift_calc #(
    parameter int n_phases = 4
) (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic [pmp_stream_pkg::value_width-1:0] period,
    input  wire logic [pmp_stream_pkg::count_width-1:0] n_active_phases,
    output logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] shifts,
    output logic shifts_ready
);

    localparam int value_width = pmp_stream_pkg::value_width;
    localparam int count_width = pmp_stream_pkg::count_width;
    localparam int num_width = value_width + count_width;
    localparam int div_width = count_width + 1;
    localparam int cnt_width = $clog2(num_width);

    logic [value_width-1:0] last_period;
    logic [count_width-1:0] last_count;
    logic [count_width-1:0] idx;
    logic in_div;
    logic computed;
    logic changed;
    logic [cnt_width-1:0] bit_cnt;
    logic [num_width-1:0] num;
    logic [num_width-1:0] num_next;
    logic [div_width-1:0] rem;
    logic [div_width-1:0] rem_next;
    logic [div_width:0] rem_shift;
    logic [div_width-1:0] divisor;

    assign changed = (period != last_period) || (n_active_phases != last_count);
    assign shifts_ready = computed && !changed;
    assign divisor = {1'b0, last_count} + div_width'(1);

    // One restoring step: the quotient bit shifts into the low end of num
    always_comb begin
        rem_shift = {rem, num[num_width-1]};
        if (rem_shift >= {1'b0, divisor}) begin
            rem_next = div_width'(rem_shift - {1'b0, divisor});
            num_next = {num[num_width-2:0], 1'b1};
        end else begin
            rem_next = rem_shift[div_width-1:0];
            num_next = {num[num_width-2:0], 1'b0};
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            last_period <= '0;
            last_count <= '0;
            idx <= '0;
            in_div <= 1'b0;
            computed <= 1'b0;
        end else if (changed) begin
            // Restart from phase 0 whenever an input moves
            last_period <= period;
            last_count <= n_active_phases;
            idx <= '0;
            in_div <= 1'b0;
            computed <= 1'b0;
        end else if (!computed && (!in_div || bit_cnt == '0)) begin
            in_div <= 1'b0;
            if (in_div) begin
                shifts[idx] <= num_next[value_width-1:0];
            end else if (idx == '0 || idx > last_count) begin
                shifts[idx] <= '0;
            end
            if (!in_div && idx != '0 && idx <= last_count) begin
                // Phase 0 and shed phases skip the divider
                num <= num_width'(last_period) * num_width'(idx);
                rem <= '0;
                bit_cnt <= cnt_width'(num_width - 1);
                in_div <= 1'b1;
            end else if (idx == count_width'(n_phases - 1)) begin
                computed <= 1'b1;
            end else begin
                idx <= idx + 1'b1;
            end
        end else if (!computed) begin
            num <= num_next;
            rem <= rem_next;
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/phase_shedder.sv
/*
 * Registered duty stage that zeroes the duty of inactive phases
 */
`timescale 1ns/1ps
`default_nettype none

module phase_shedder #(
    parameter int n_phases = 4
) (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] duty,
    input  wire logic [pmp_stream_pkg::count_width-1:0] n_active_phases,
    output logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] duty_active
);

    // Phases above the active count are shed at light load
    always_ff @(posedge clock) begin
        if (rst) begin
            duty_active <= '0;
        end else begin
            for (int k = 0; k < n_phases; k++) begin
                if (k <= n_active_phases) begin
                    duty_active[k] <= duty[k];
                end else begin
                    duty_active[k] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pwm_setup_sequencer.sv
/*
 * Configure, start and stop write sequences for the PWM generator channels
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_setup_sequencer #(
    parameter logic [pmp_stream_pkg::addr_width-1:0] pwm_base_addr = '0,
    parameter int n_phases = 4
) (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic configure,
    input  wire logic start,
    input  wire logic stop,
    input  wire logic [pmp_stream_pkg::value_width-1:0] deadtime,
    output logic done,
    output logic config_done,
    reg_write_if.source setup_write
);

    localparam int addr_width = pmp_stream_pkg::addr_width;
    localparam int data_width = pmp_stream_pkg::data_width;
    localparam int beat_width = $clog2(2 * n_phases);

    typedef enum logic [1:0] {s_idle, s_config, s_start, s_stop} seq_state_t;

    seq_state_t state;
    logic [beat_width-1:0] beat;
    logic [beat_width-1:0] last_beat;
    logic [addr_width-1:0] channel;
    logic [addr_width-1:0] offset;
    logic [pmp_stream_pkg::value_width-1:0] deadtime_q;
    logic fire;

    // Configure walks deadtime then enable for each channel
    always_comb begin
        if (state == s_config) begin
            channel = addr_width'(beat >> 1);
            offset = beat[0] ? pmp_regmap_pkg::reg_control : pmp_regmap_pkg::reg_deadtime;
            setup_write.data = beat[0] ? pmp_regmap_pkg::ctrl_enable : data_width'(deadtime_q);
            last_beat = beat_width'(2 * n_phases - 1);
        end else begin
            channel = addr_width'(beat);
            offset = pmp_regmap_pkg::reg_control;
            if (state == s_start) begin
                setup_write.data = pmp_regmap_pkg::ctrl_start;
            end else begin
                setup_write.data = pmp_regmap_pkg::ctrl_stop;
            end
            last_beat = beat_width'(n_phases - 1);
        end
    end

    assign setup_write.addr = pwm_base_addr + channel * pmp_regmap_pkg::channel_stride + offset;
    assign setup_write.valid = (state != s_idle);
    assign setup_write.last = (beat == last_beat);
    assign fire = setup_write.valid && setup_write.ready;

    always_ff @(posedge clock) begin
        if (state == s_idle && configure) begin
            deadtime_q <= deadtime;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= s_idle;
            beat <= '0;
            done <= 1'b0;
            config_done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == s_idle) begin
                beat <= '0;
                if (configure) begin
                    state <= s_config;
                end else if (start) begin
                    state <= s_start;
                end else if (stop) begin
                    state <= s_stop;
                end
            end else if (fire && setup_write.last) begin
                state <= s_idle;
                if (state == s_config) begin
                    done <= 1'b1;
                    config_done <= 1'b1;
                end
            end else if (fire) begin
                beat <= beat + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/modulation_writer.sv
/*
 * Modulator run state and the period, duty and shift update bursts
 */
`timescale 1ns/1ps
`default_nettype none

module modulation_writer #(
    parameter logic [pmp_stream_pkg::addr_width-1:0] pwm_base_addr = '0,
    parameter int n_phases = 4
) (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic stop,
    input  wire logic config_done,
    input  wire logic [n_phases-1:0] update,
    input  wire logic [pmp_stream_pkg::value_width-1:0] period,
    input  wire logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] duty_active,
    input  wire logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] shifts,
    input  wire logic shifts_ready,
    input  wire logic setup_last_done,
    output logic modulator_status,
    reg_write_if.source operating_write
);

    localparam int addr_width = pmp_stream_pkg::addr_width;
    localparam int data_width = pmp_stream_pkg::data_width;
    localparam int count_width = pmp_stream_pkg::count_width;

    typedef enum logic [2:0] {w_idle, w_wait, w_period, w_duty, w_shift} wr_state_t;

    wr_state_t state;
    logic [n_phases-1:0] mask;
    logic [n_phases-1:0] rest_mask;
    logic [count_width-1:0] phase;
    logic [pmp_stream_pkg::value_width-1:0] period_q;
    logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] duty_q;
    logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] shift_q;
    logic [addr_width-1:0] channel;
    logic [addr_width-1:0] offset;
    logic start_pending;
    logic stop_pending;
    logic fire;

    // Lowest set bit of the remaining mask is the phase being written
    always_comb begin
        phase = '0;
        for (int k = n_phases - 1; k >= 0; k--) begin
            if (mask[k]) begin
                phase = count_width'(k);
            end
        end
    end

    assign rest_mask = mask & (mask - 1'b1);

    always_comb begin
        channel = addr_width'(phase);
        case (state)
            w_duty: begin
                offset = pmp_regmap_pkg::reg_duty;
                operating_write.data = data_width'(duty_q[phase]);
            end
            w_shift: begin
                offset = pmp_regmap_pkg::reg_shift;
                operating_write.data = data_width'(shift_q[phase]);
            end
            default: begin
                // The period is shared and goes to channel 0
                channel = '0;
                offset = pmp_regmap_pkg::reg_period;
                operating_write.data = data_width'(period_q);
            end
        endcase
    end

    assign operating_write.addr = pwm_base_addr + channel * pmp_regmap_pkg::channel_stride
        + offset;
    assign operating_write.valid = (state == w_period) || (state == w_duty) || (state == w_shift);
    assign operating_write.last = (state == w_shift) && (rest_mask == '0);
    assign fire = operating_write.valid && operating_write.ready;

    // Snapshot the burst payload so a stalled beat stays stable
    always_ff @(posedge clock) begin
        if (state == w_wait && shifts_ready) begin
            period_q <= period;
            duty_q <= duty_active;
            shift_q <= shifts;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= w_idle;
            mask <= '0;
            modulator_status <= 1'b0;
            start_pending <= 1'b0;
            stop_pending <= 1'b0;
        end else begin
            // Status follows the completion of a start or stop burst
            if (setup_last_done) begin
                if (start_pending && config_done) begin
                    modulator_status <= 1'b1;
                end
                if (stop_pending) begin
                    modulator_status <= 1'b0;
                end
                start_pending <= 1'b0;
                stop_pending <= 1'b0;
            end else if (!start_pending && !stop_pending) begin
                start_pending <= start;
                stop_pending <= stop && !start;
            end

            case (state)
                w_idle: begin
                    if (modulator_status && update != '0) begin
                        mask <= update;
                        state <= w_wait;
                    end
                end
                w_wait: if (shifts_ready) state <= w_period;
                w_period: if (fire) state <= w_duty;
                w_duty: if (fire) state <= w_shift;
                default: begin
                    if (fire) begin
                        mask <= rest_mask;
                        state <= (rest_mask == '0) ? w_idle : w_duty;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/write_arbiter.sv
/*
 * Burst-locked arbiter merging the setup and operating write streams
 */
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
    input  wire logic clock,
    input  wire logic rst,
    reg_write_if.sink setup_write,
    reg_write_if.sink operating_write,
    output logic [pmp_stream_pkg::data_width-1:0] write_data,
    output logic [pmp_stream_pkg::addr_width-1:0] write_addr,
    output logic write_last,
    output logic write_valid,
    input  wire logic write_ready
);

    logic locked;
    logic owner_op;
    logic sel_op;

    // Between bursts the operating stream has priority
    assign sel_op = locked ? owner_op : operating_write.valid;

    always_comb begin
        if (sel_op) begin
            write_data = operating_write.data;
            write_addr = operating_write.addr;
            write_last = operating_write.last;
            write_valid = operating_write.valid;
        end else begin
            write_data = setup_write.data;
            write_addr = setup_write.addr;
            write_last = setup_write.last;
            write_valid = setup_write.valid;
        end
    end

    assign operating_write.ready = write_ready && sel_op;
    assign setup_write.ready = write_ready && !sel_op;

    // Hold the grant from the first offered beat until the last one transfers
    always_ff @(posedge clock) begin
        if (rst) begin
            locked <= 1'b0;
            owner_op <= 1'b0;
        end else if (write_valid) begin
            locked <= !(write_ready && write_last);
            owner_op <= sel_op;
        end
    end

endmodule

`default_nettype wire

// File: src/buck_pre_modulation_processor.sv
/*
 * Multiphase buck pre-modulation processor top level
 */
`timescale 1ns/1ps
`default_nettype none

module buck_pre_modulation_processor #(
    parameter logic [pmp_stream_pkg::addr_width-1:0] pwm_base_addr = '0,
    parameter int n_phases = 4
) (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic configure,
    input  wire logic start,
    input  wire logic stop,
    input  wire logic [n_phases-1:0] update,
    input  wire logic [pmp_stream_pkg::value_width-1:0] period,
    input  wire logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] duty,
    input  wire logic [pmp_stream_pkg::value_width-1:0] deadtime,
    input  wire logic [pmp_stream_pkg::count_width-1:0] n_active_phases,
    output logic done,
    output logic modulator_status,
    output logic [pmp_stream_pkg::data_width-1:0] write_data,
    output logic [pmp_stream_pkg::addr_width-1:0] write_addr,
    output logic write_last,
    output logic write_valid,
    input  wire logic write_ready
);

    logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] shifts;
    logic [n_phases-1:0][pmp_stream_pkg::value_width-1:0] duty_active;
    logic shifts_ready;
    logic config_done;
    logic setup_last_done;

    reg_write_if setup_write ();
    reg_write_if operating_write ();

    // Completion of a setup burst, used to track the run state
    assign setup_last_done = setup_write.valid && setup_write.ready && setup_write.last;

    phase_shift_calc #(.n_phases(n_phases)) shift_calc_i (
        .clock(clock), .rst(rst), .period(period), .n_active_phases(n_active_phases),
        .shifts(shifts), .shifts_ready(shifts_ready)
    );

    phase_shedder #(.n_phases(n_phases)) shedder_i (
        .clock(clock), .rst(rst), .duty(duty), .n_active_phases(n_active_phases),
        .duty_active(duty_active)
    );

    pwm_setup_sequencer #(.pwm_base_addr(pwm_base_addr), .n_phases(n_phases)) setup_i (
        .clock(clock), .rst(rst), .configure(configure), .start(start), .stop(stop),
        .deadtime(deadtime), .done(done), .config_done(config_done),
        .setup_write(setup_write.source)
    );

    modulation_writer #(.pwm_base_addr(pwm_base_addr), .n_phases(n_phases)) writer_i (
        .clock(clock), .rst(rst), .start(start), .stop(stop), .config_done(config_done),
        .update(update), .period(period), .duty_active(duty_active), .shifts(shifts),
        .shifts_ready(shifts_ready), .setup_last_done(setup_last_done),
        .modulator_status(modulator_status), .operating_write(operating_write.source)
    );

    write_arbiter arbiter_i (
        .clock(clock), .rst(rst),
        .setup_write(setup_write.sink), .operating_write(operating_write.sink),
        .write_data(write_data), .write_addr(write_addr), .write_last(write_last),
        .write_valid(write_valid), .write_ready(write_ready)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/*
 * Testbench clock and power-on reset generator
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 20,
    parameter int reset_cycles = 3
) (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // Reset covers the first few rising edges, then drops just after one
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/pmp_checker.sv
/*
 * Write stream checker: expected-write queue, stall stability check,
 * error counting and done pulse counting
 */
`timescale 1ns/1ps
`default_nettype none

module pmp_checker (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic [pmp_stream_pkg::data_width-1:0] write_data,
    input  wire logic [pmp_stream_pkg::addr_width-1:0] write_addr,
    input  wire logic write_last,
    input  wire logic write_valid,
    input  wire logic write_ready,
    input  wire logic done,
    output int error_count,
    output int done_count
);

    typedef struct packed {
        logic [pmp_stream_pkg::addr_width-1:0] addr;
        logic [pmp_stream_pkg::data_width-1:0] data;
        logic last;
    } beat_t;

    beat_t expected_q[$];
    beat_t held;
    beat_t seen;
    logic stalled;

    task automatic expect_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic last);
        beat_t b;
        b.addr = addr;
        b.data = data;
        b.last = last;
        expected_q.push_back(b);
    endtask

    function automatic int pending_count();
        return expected_q.size();
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic compare_fields(input beat_t exp, input beat_t act);
        if (act.addr !== exp.addr) report_mismatch("write_addr", exp.addr, act.addr);
        if (act.data !== exp.data) report_mismatch("write_data", exp.data, act.data);
        if (act.last !== exp.last) report_mismatch("write_last", 32'(exp.last), 32'(act.last));
    endtask

    // Sampled at the falling edge, where every DUT input and output is settled
    always @(negedge clock) begin
        if (rst) begin
            error_count = 0;
            done_count = 0;
            stalled = 1'b0;
        end else begin
            seen.addr = write_addr;
            seen.data = write_data;
            seen.last = write_last;
            if (done) done_count++;
            if (stalled) begin
                // A held beat must stay offered and unchanged
                if (!write_valid) begin
                    $display("write_valid dropped at %0t ns while a beat was stalled", $time);
                    error_count++;
                end else begin
                    compare_fields(held, seen);
                end
            end
            if (write_valid && write_ready) begin
                if (expected_q.size() == 0) begin
                    $display("unexpected write at %0t ns to address %h with data %h",
                             $time, write_addr, write_data);
                    error_count++;
                end else begin
                    compare_fields(expected_q.pop_front(), seen);
                end
            end
            stalled = write_valid && !write_ready;
            held = seen;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_buck_pmp.sv
/*
 * Testbench top: random stimulus, expected-write model and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_buck_pmp;

    localparam int n_phases = 4;
    localparam int value_width = pmp_stream_pkg::value_width;
    localparam logic [31:0] base_addr = 32'h4000_0000;
    localparam int n_updates = 40;
    localparam int timeout_ns = n_updates * (2 + 2 * n_phases) * 20 * 20 + 50000;

    logic clock;
    logic rst;
    logic configure;
    logic start;
    logic stop;
    logic [n_phases-1:0] update;
    logic [value_width-1:0] period;
    logic [n_phases-1:0][value_width-1:0] duty;
    logic [value_width-1:0] deadtime;
    logic [pmp_stream_pkg::count_width-1:0] n_active_phases;
    logic done;
    logic modulator_status;
    logic [31:0] write_data;
    logic [31:0] write_addr;
    logic write_last;
    logic write_valid;
    logic write_ready;
    logic [n_phases-1:0] mask;
    logic stall_on;
    int seed;
    int tb_errors;
    int error_count;
    int done_count;

    tb_clock_gen #(.period_ns(20), .reset_cycles(3)) clock_gen_i (.clock(clock), .rst(rst));

    buck_pre_modulation_processor #(.pwm_base_addr(base_addr), .n_phases(n_phases)) dut_i (
        .clock(clock), .rst(rst), .configure(configure), .start(start), .stop(stop),
        .update(update), .period(period), .duty(duty), .deadtime(deadtime),
        .n_active_phases(n_active_phases), .done(done), .modulator_status(modulator_status),
        .write_data(write_data), .write_addr(write_addr), .write_last(write_last),
        .write_valid(write_valid), .write_ready(write_ready)
    );

    pmp_checker checker_i (
        .clock(clock), .rst(rst), .write_data(write_data), .write_addr(write_addr),
        .write_last(write_last), .write_valid(write_valid), .write_ready(write_ready),
        .done(done), .error_count(error_count), .done_count(done_count)
    );

    // Inputs change 1 ns after the rising edge, back-pressure included
    task automatic next_cycle();
        @(posedge clock);
        #1;
        write_ready = stall_on ? (($random(seed) & 3) != 0) : 1'b1;
    endtask

    task automatic drain_writes();
        while (checker_i.pending_count() != 0) next_cycle();
        next_cycle();
    endtask

    task automatic compare_signal(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    function automatic logic [31:0] channel_addr(input int k, input logic [31:0] offset);
        return base_addr + k * pmp_regmap_pkg::channel_stride + offset;
    endfunction

    task automatic push_control_burst(input logic [31:0] word);
        for (int k = 0; k < n_phases; k++) begin
            checker_i.expect_write(channel_addr(k, pmp_regmap_pkg::reg_control), word,
                                   k == n_phases - 1);
        end
    endtask

    // Shed phases get zero duty and zero shift; shift is period*k/active
    task automatic push_update_burst();
        int active;
        int top_bit;
        logic [31:0] shift;
        active = int'(n_active_phases) + 1;
        top_bit = 0;
        for (int k = 0; k < n_phases; k++) if (mask[k]) top_bit = k;
        checker_i.expect_write(base_addr + pmp_regmap_pkg::reg_period, 32'(period), 1'b0);
        for (int k = 0; k < n_phases; k++) begin
            if (mask[k]) begin
                shift = (k < active) ? (32'(period) * k) / active : 32'h0;
                checker_i.expect_write(channel_addr(k, pmp_regmap_pkg::reg_duty),
                                       (k < active) ? 32'(duty[k]) : 32'h0, 1'b0);
                checker_i.expect_write(channel_addr(k, pmp_regmap_pkg::reg_shift), shift,
                                       k == top_bit);
            end
        end
    endtask

    task automatic randomize_operating_point();
        period = $random(seed);
        for (int k = 0; k < n_phases; k++) duty[k] = $random(seed);
        n_active_phases = $random(seed) & 3;
        mask = $random(seed);
        if (mask == '0) mask = 1;
    endtask

    task automatic pulse_update();
        update = mask;
        next_cycle();
        update = '0;
    endtask

    initial begin
        seed = 32'h64943f7e;
        tb_errors = 0;
        stall_on = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = '0;
        period = '0;
        duty = '0;
        deadtime = '0;
        n_active_phases = '0;
        mask = '0;
        write_ready = 1'b1;
        @(negedge rst);
        next_cycle();
        compare_signal("write_valid", 0, 32'(write_valid));
        compare_signal("done", 0, 32'(done));
        compare_signal("modulator_status", 0, 32'(modulator_status));

        // An update before configure must produce no writes
        randomize_operating_point();
        pulse_update();
        repeat (30) next_cycle();

        deadtime = $random(seed);
        for (int k = 0; k < n_phases; k++) begin
            checker_i.expect_write(channel_addr(k, pmp_regmap_pkg::reg_deadtime),
                                   32'(deadtime), 1'b0);
            checker_i.expect_write(channel_addr(k, pmp_regmap_pkg::reg_control),
                                   pmp_regmap_pkg::ctrl_enable, k == n_phases - 1);
        end
        configure = 1'b1;
        next_cycle();
        configure = 1'b0;
        while (!done) next_cycle();
        if (checker_i.pending_count() != 0) begin
            $display("done pulsed at %0t ns before the configure burst completed", $time);
            tb_errors++;
        end

        push_control_burst(pmp_regmap_pkg::ctrl_start);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        drain_writes();
        compare_signal("modulator_status", 1, 32'(modulator_status));

        // Second half of the updates runs with random back-pressure
        for (int i = 0; i < n_updates; i++) begin
            stall_on = (i >= n_updates / 2);
            randomize_operating_point();
            next_cycle();
            push_update_burst();
            pulse_update();
            drain_writes();
        end

        // Start arrives while an update burst streams and must queue behind it
        randomize_operating_point();
        next_cycle();
        push_update_burst();
        push_control_burst(pmp_regmap_pkg::ctrl_start);
        pulse_update();
        while (!write_valid) next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        drain_writes();
        compare_signal("modulator_status", 1, 32'(modulator_status));

        push_control_burst(pmp_regmap_pkg::ctrl_stop);
        stop = 1'b1;
        next_cycle();
        stop = 1'b0;
        drain_writes();
        compare_signal("modulator_status", 0, 32'(modulator_status));
        randomize_operating_point();
        pulse_update();
        repeat (30) next_cycle();

        compare_signal("done pulse count", 1, 32'(done_count));
        $display("checker errors %0d, testbench errors %0d, writes still expected %0d",
                 error_count, tb_errors, checker_i.pending_count());
        if (error_count == 0 && tb_errors == 0 && checker_i.pending_count() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns", timeout_ns);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: buck_pmp.f
src/pmp_stream_pkg.sv
src/pmp_regmap_pkg.sv
src/reg_write_if.sv
src/phase_shift_calc.sv
src/phase_shedder.sv
src/pwm_setup_sequencer.sv
src/modulation_writer.sv
src/write_arbiter.sv
src/buck_pre_modulation_processor.sv
verification/tb_clock_gen.sv
verification/pmp_checker.sv
verification/tb_buck_pmp.sv

// File: Makefile
# Verilator build and run of the buck pre-modulation processor testbench

VERILATOR ?= verilator
TOP ?= tb_buck_pmp
FILE_LIST ?= buck_pmp.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)
